// File: include/hci_settings.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// HCI front end sizes and map
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef HCI_SETTINGS_SVH
`define HCI_SETTINGS_SVH

`define HCI_QUEUE_DEPTH 8
`define HCI_DEPTH_W 4      // Counts 0 to 8
`define HCI_THLD_W 8
`define HCI_CSR_AW 8
`define HCI_THLD_RST 8'd1

// Byte addresses
`define HCI_ADDR_RESET_CTRL 8'h04
`define HCI_ADDR_COMMAND_PORT 8'h0C
`define HCI_ADDR_RESPONSE_PORT 8'h10
`define HCI_ADDR_QUEUE_THLD 8'h14
`define HCI_ADDR_DEVICE_ADDR 8'h20

`define HCI_CMD_RST_BIT 1
`define HCI_RESP_RST_BIT 2

`endif

// File: rtl/hci_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// HCI shared types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "hci_settings.svh"

package hci_pkg;

  typedef struct packed {
    logic                   req;
    logic                   is_wr;
    logic [`HCI_CSR_AW-1:0] addr;
    logic [31:0]            wdata;
  } cpu_req_t;

  typedef struct packed {
    logic        rd_ack;
    logic        rd_err;
    logic [31:0] rd_data;
    logic        wr_ack;
    logic        wr_err;
  } cpu_rsp_t;

  typedef struct packed {
    logic                    full;
    logic                    empty;
    logic [`HCI_DEPTH_W-1:0] depth;
    logic                    thld_trig;
  } queue_status_t;

  typedef logic [63:0] hci_cmd_t;
  typedef logic [31:0] hci_resp_t;

  typedef enum logic [`HCI_CSR_AW-1:0] {
    REG_RESET_CTRL    = `HCI_ADDR_RESET_CTRL,
    REG_COMMAND_PORT  = `HCI_ADDR_COMMAND_PORT,
    REG_RESPONSE_PORT = `HCI_ADDR_RESPONSE_PORT,
    REG_QUEUE_THLD    = `HCI_ADDR_QUEUE_THLD,
    REG_DEVICE_ADDR   = `HCI_ADDR_DEVICE_ADDR
  } hci_reg_e;

  // Which half of a command the next write fills
  typedef enum logic {
    CMD_LOW,
    CMD_HIGH
  } cmd_half_e;

endpackage

// File: rtl/hci_queue.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// HCI queue, synchronous FIFO
// with threshold trigger and flush
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "hci_settings.svh"

module hci_queue
  import hci_pkg::*;
#(
  parameter int unsigned DataWidth = 32,
  parameter bit          CountFree = 1'b0
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   push_i,
  input  logic [DataWidth-1:0]   push_data_i,
  input  logic                   pop_i,
  output logic [DataWidth-1:0]   head_o,
  input  logic                   flush_i,
  input  logic [`HCI_THLD_W-1:0] thld_i,
  output queue_status_t          status_o
);

  localparam int unsigned PtrW = $clog2(`HCI_QUEUE_DEPTH);
  localparam logic [`HCI_DEPTH_W-1:0] Depth = `HCI_QUEUE_DEPTH;

  logic [DataWidth-1:0] mem_q [`HCI_QUEUE_DEPTH];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [`HCI_DEPTH_W-1:0] count_q;
  logic full;
  logic empty;
  logic push_ok;
  logic pop_ok;
  logic [`HCI_DEPTH_W-1:0] level;
  logic [`HCI_THLD_W-1:0] thld_eff;

  assign full = (count_q == Depth);
  assign empty = (count_q == '0);
  assign push_ok = push_i && !full;   // Overflow is dropped
  assign pop_ok = pop_i && !empty;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_ok) wr_ptr_q <= wr_ptr_q + 1'b1;   // Wraps at depth
      if (pop_ok) rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({push_ok, pop_ok})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_ok) mem_q[wr_ptr_q] <= push_data_i;
  end

  // First word fall through
  assign head_o = mem_q[rd_ptr_q];

  // Free slots for the command side, stored entries for responses
  assign level = CountFree ? (Depth - count_q) : count_q;
  assign thld_eff = (thld_i == '0) ? {{(`HCI_THLD_W-1){1'b0}}, 1'b1} : thld_i;

  always_comb begin
    status_o.full = full;
    status_o.empty = empty;
    status_o.depth = count_q;
    status_o.thld_trig = {{(`HCI_THLD_W-`HCI_DEPTH_W){1'b0}}, level} >= thld_eff;
  end

endmodule

// File: rtl/hci_csr.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// HCI register block, command
// packer and queue control
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "hci_settings.svh"

module hci_csr
  import hci_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  cpu_req_t               cpu_req_i,
  output cpu_rsp_t               cpu_rsp_o,
  output logic                   cmd_push_o,
  output hci_cmd_t               cmd_o,
  output logic                   cmd_flush_o,
  output logic [`HCI_THLD_W-1:0] cmd_thld_o,
  output logic                   resp_pop_o,
  input  hci_resp_t              resp_head_i,
  input  queue_status_t          resp_status_i,
  output logic                   resp_flush_o,
  output logic [`HCI_THLD_W-1:0] resp_thld_o,
  input  logic [6:0]             set_dasa_i,
  input  logic                   set_dasa_valid_i,
  input  logic                   rstdaa_i
);

  hci_reg_e reg_sel;
  logic rd_req;
  logic wr_req;
  logic cmd_wr;
  logic rst_wr;
  cmd_half_e half_q;
  logic [31:0] cmd_low_q;
  logic [`HCI_THLD_W-1:0] cmd_thld_q;
  logic [`HCI_THLD_W-1:0] resp_thld_q;
  logic cmd_rst_q;
  logic resp_rst_q;
  logic dasa_valid_q;
  logic [6:0] dasa_q;
  cpu_rsp_t rsp_d;
  cpu_rsp_t rsp_q;

  assign reg_sel = hci_reg_e'(cpu_req_i.addr);
  assign rd_req = cpu_req_i.req && !cpu_req_i.is_wr;
  assign wr_req = cpu_req_i.req && cpu_req_i.is_wr;
  assign cmd_wr = wr_req && (reg_sel == REG_COMMAND_PORT);
  assign rst_wr = wr_req && (reg_sel == REG_RESET_CTRL);

  // Read mux and error decode
  always_comb begin
    rsp_d = '0;
    rsp_d.rd_ack = rd_req;
    rsp_d.wr_ack = wr_req;
    if (rd_req) begin
      case (reg_sel)
        REG_RESET_CTRL: begin
          rsp_d.rd_data[`HCI_CMD_RST_BIT] = cmd_rst_q;
          rsp_d.rd_data[`HCI_RESP_RST_BIT] = resp_rst_q;
        end
        REG_COMMAND_PORT: ;   // Write only, reads as 0
        REG_RESPONSE_PORT: begin
          if (!resp_status_i.empty) rsp_d.rd_data = resp_head_i;
        end
        REG_QUEUE_THLD: begin
          rsp_d.rd_data[`HCI_THLD_W-1:0] = cmd_thld_q;
          rsp_d.rd_data[2*`HCI_THLD_W-1:`HCI_THLD_W] = resp_thld_q;
        end
        REG_DEVICE_ADDR: begin
          rsp_d.rd_data[31] = dasa_valid_q;
          rsp_d.rd_data[6:0] = dasa_q;
        end
        default: rsp_d.rd_err = 1'b1;
      endcase
    end
    if (wr_req) begin
      case (reg_sel)
        REG_RESET_CTRL, REG_COMMAND_PORT, REG_QUEUE_THLD: ;
        default: rsp_d.wr_err = 1'b1;   // Read-only or unmapped
      endcase
    end
  end

  // Pop in the same edge that captures the head
  assign resp_pop_o = rd_req && (reg_sel == REG_RESPONSE_PORT) && !resp_status_i.empty;

  assign cmd_push_o = cmd_wr && (half_q == CMD_HIGH);
  assign cmd_o = {cpu_req_i.wdata, cmd_low_q};

  assign cmd_flush_o = cmd_rst_q;
  assign resp_flush_o = resp_rst_q;
  assign cmd_thld_o = cmd_thld_q;
  assign resp_thld_o = resp_thld_q;
  assign cpu_rsp_o = rsp_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_q        <= '0;
      half_q       <= CMD_LOW;
      cmd_thld_q   <= `HCI_THLD_RST;
      resp_thld_q  <= `HCI_THLD_RST;
      cmd_rst_q    <= 1'b0;
      resp_rst_q   <= 1'b0;
      dasa_valid_q <= 1'b0;
      dasa_q       <= '0;
    end else begin
      rsp_q <= rsp_d;

      // Self clearing one cycle after the write
      cmd_rst_q  <= rst_wr && cpu_req_i.wdata[`HCI_CMD_RST_BIT];
      resp_rst_q <= rst_wr && cpu_req_i.wdata[`HCI_RESP_RST_BIT];

      if (wr_req && (reg_sel == REG_QUEUE_THLD)) begin
        cmd_thld_q  <= cpu_req_i.wdata[`HCI_THLD_W-1:0];
        resp_thld_q <= cpu_req_i.wdata[2*`HCI_THLD_W-1:`HCI_THLD_W];
      end

      if (cmd_rst_q) begin
        half_q <= CMD_LOW;   // Drop a half written command
      end else if (cmd_wr) begin
        half_q <= (half_q == CMD_LOW) ? CMD_HIGH : CMD_LOW;
      end

      // RSTDAA wins over SETDASA
      if (rstdaa_i) begin
        dasa_valid_q <= 1'b0;
        dasa_q       <= '0;
      end else if (set_dasa_valid_i) begin
        dasa_valid_q <= 1'b1;
        dasa_q       <= set_dasa_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_wr && (half_q == CMD_LOW)) cmd_low_q <= cpu_req_i.wdata;
  end

endmodule

// File: rtl/hci_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// HCI front end top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module hci_top
  import hci_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_ni,
  input  cpu_req_t      cpu_req_i,
  output cpu_rsp_t      cpu_rsp_o,
  input  logic          cmd_pop_i,
  output hci_cmd_t      cmd_data_o,
  output queue_status_t cmd_status_o,
  input  logic          resp_push_i,
  input  hci_resp_t     resp_data_i,
  output queue_status_t resp_status_o,
  input  logic [6:0]    set_dasa_i,
  input  logic          set_dasa_valid_i,
  input  logic          rstdaa_i
);

  logic cmd_push;
  hci_cmd_t cmd_word;
  logic cmd_flush;
  logic [7:0] cmd_thld;
  logic resp_pop;
  hci_resp_t resp_head;
  logic resp_flush;
  logic [7:0] resp_thld;

  hci_csr u_csr (
    .clk_i,
    .rst_ni,
    .cpu_req_i,
    .cpu_rsp_o,
    .cmd_push_o    (cmd_push),
    .cmd_o         (cmd_word),
    .cmd_flush_o   (cmd_flush),
    .cmd_thld_o    (cmd_thld),
    .resp_pop_o    (resp_pop),
    .resp_head_i   (resp_head),
    .resp_status_i (resp_status_o),
    .resp_flush_o  (resp_flush),
    .resp_thld_o   (resp_thld),
    .set_dasa_i,
    .set_dasa_valid_i,
    .rstdaa_i
  );

  // Command queue triggers on free slots
  hci_queue #(
    .DataWidth (64),
    .CountFree (1'b1)
  ) u_cmd_queue (
    .clk_i,
    .rst_ni,
    .push_i      (cmd_push),
    .push_data_i (cmd_word),
    .pop_i       (cmd_pop_i),
    .head_o      (cmd_data_o),
    .flush_i     (cmd_flush),
    .thld_i      (cmd_thld),
    .status_o    (cmd_status_o)
  );

  hci_queue #(
    .DataWidth (32),
    .CountFree (1'b0)
  ) u_resp_queue (
    .clk_i,
    .rst_ni,
    .push_i      (resp_push_i),
    .push_data_i (resp_data_i),
    .pop_i       (resp_pop),
    .head_o      (resp_head),
    .flush_i     (resp_flush),
    .thld_i      (resp_thld),
    .status_o    (resp_status_o)
  );

endmodule

// File: bench/hci_sva.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// HCI register port and queue
// status assertions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "hci_settings.svh"

module hci_sva
  import hci_pkg::*;
(
  input logic          clk_i,
  input logic          rst_ni,
  input cpu_req_t      cpu_req_i,
  input cpu_rsp_t      cpu_rsp_i,
  input queue_status_t cmd_status_i,
  input queue_status_t resp_status_i
);

  localparam logic [`HCI_DEPTH_W-1:0] MaxDepth = `HCI_QUEUE_DEPTH;

  logic rd_req;
  logic wr_req;

  assign rd_req = cpu_req_i.req && !cpu_req_i.is_wr;
  assign wr_req = cpu_req_i.req && cpu_req_i.is_wr;

  rd_ack_follows: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_req |=> cpu_rsp_i.rd_ack) else $error("read request without rd_ack a cycle later");
  wr_ack_follows: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr_req |=> cpu_rsp_i.wr_ack) else $error("write request without wr_ack a cycle later");
  acks_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(cpu_rsp_i.rd_ack && cpu_rsp_i.wr_ack)) else $error("rd_ack and wr_ack high together");
  cmd_full_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(cmd_status_i.full && cmd_status_i.empty)) else $error("command queue full and empty");
  resp_full_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(resp_status_i.full && resp_status_i.empty)) else $error("response queue full and empty");
  cmd_depth_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_status_i.depth <= MaxDepth) else $error("command queue depth above limit");
  resp_depth_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_status_i.depth <= MaxDepth) else $error("response queue depth above limit");

endmodule

// File: bench/hci_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// HCI front end testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "hci_settings.svh"

module hci_tb
  import hci_pkg::*;
();

  localparam int unsigned TimeoutCycles = 2000;
  localparam int unsigned Seed = 32'h4b30;

  logic clk;
  logic rst_n;
  cpu_req_t cpu_req;
  cpu_rsp_t cpu_rsp;
  logic cmd_pop;
  hci_cmd_t cmd_data;
  queue_status_t cmd_status;
  logic resp_push;
  hci_resp_t resp_data;
  queue_status_t resp_status;
  logic [6:0] set_dasa;
  logic set_dasa_valid;
  logic rstdaa;
  int unsigned cycles = 0;

  hci_top i_dut (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .cpu_req_i        (cpu_req),
    .cpu_rsp_o        (cpu_rsp),
    .cmd_pop_i        (cmd_pop),
    .cmd_data_o       (cmd_data),
    .cmd_status_o     (cmd_status),
    .resp_push_i      (resp_push),
    .resp_data_i      (resp_data),
    .resp_status_o    (resp_status),
    .set_dasa_i       (set_dasa),
    .set_dasa_valid_i (set_dasa_valid),
    .rstdaa_i         (rstdaa)
  );

  bind hci_top hci_sva u_sva (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cpu_req_i     (cpu_req_i),
    .cpu_rsp_i     (cpu_rsp_o),
    .cmd_status_i  (cmd_status_o),
    .resp_status_i (resp_status_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("test failed");
    $fatal(1, "stopping at the first error");
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TimeoutCycles) report_failure("timeout, the tests did not finish in time");
  end

  task automatic check_cmd(input string name, input hci_cmd_t exp, input hci_cmd_t act);
    if (exp !== act) report_failure($sformatf("mismatch %s: expected %h actual %h", name, exp, act));
  endtask

  task automatic check_resp(input string name, input hci_resp_t exp, input hci_resp_t act);
    if (exp !== act) report_failure($sformatf("mismatch %s: expected %h actual %h", name, exp, act));
  endtask

  task automatic check_status(input string name, input queue_status_t exp,
                              input queue_status_t act);
    if (exp !== act) report_failure($sformatf("mismatch %s: expected %h actual %h", name, exp, act));
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) report_failure($sformatf("mismatch %s: expected %h actual %h", name, exp, act));
  endtask

  // Reference status from depth, threshold and counting mode
  function automatic queue_status_t expect_status(input int count, input int thld,
                                                  input bit count_free);
    queue_status_t s;
    int level;
    int eff;
    level = count_free ? (`HCI_QUEUE_DEPTH - count) : count;
    eff = (thld < 1) ? 1 : thld;
    s.full = (count == `HCI_QUEUE_DEPTH);
    s.empty = (count == 0);
    s.depth = count[`HCI_DEPTH_W-1:0];
    s.thld_trig = (level >= eff);
    return s;
  endfunction

  // All tasks start and end right after a falling edge
  task automatic csr_write(input logic [`HCI_CSR_AW-1:0] addr, input logic [31:0] data,
                           output logic err);
    cpu_req.req = 1'b1;
    cpu_req.is_wr = 1'b1;
    cpu_req.addr = addr;
    cpu_req.wdata = data;
    @(negedge clk);
    cpu_req = '0;
    if (!cpu_rsp.wr_ack) report_failure($sformatf("write to address %h got no wr_ack", addr));
    err = cpu_rsp.wr_err;
  endtask

  task automatic csr_read(input logic [`HCI_CSR_AW-1:0] addr, output logic [31:0] data,
                          output logic err);
    cpu_req.req = 1'b1;
    cpu_req.is_wr = 1'b0;
    cpu_req.addr = addr;
    cpu_req.wdata = '0;
    @(negedge clk);
    cpu_req = '0;
    if (!cpu_rsp.rd_ack) report_failure($sformatf("read of address %h got no rd_ack", addr));
    data = cpu_rsp.rd_data;
    err = cpu_rsp.rd_err;
  endtask

  task automatic send_cmd(input hci_cmd_t cmd);
    logic err;
    csr_write(`HCI_ADDR_COMMAND_PORT, cmd[31:0], err);
    check_word("command low word wr_err", 32'd0, {31'd0, err});
    csr_write(`HCI_ADDR_COMMAND_PORT, cmd[63:32], err);
    check_word("command high word wr_err", 32'd0, {31'd0, err});
  endtask

  task automatic pop_cmd();
    cmd_pop = 1'b1;
    @(negedge clk);
    cmd_pop = 1'b0;
  endtask

  task automatic push_resp(input hci_resp_t data);
    resp_push = 1'b1;
    resp_data = data;
    @(negedge clk);
    resp_push = 1'b0;
  endtask

  task automatic dasa_strobe(input logic [6:0] addr, input logic set, input logic clear);
    set_dasa = addr;
    set_dasa_valid = set;
    rstdaa = clear;
    @(negedge clk);
    set_dasa_valid = 1'b0;
    rstdaa = 1'b0;
  endtask

  task automatic test_cmd_path();
    hci_cmd_t sent [$];
    hci_cmd_t cmd;
    for (int i = 0; i < 9; i++) begin
      cmd = {$urandom(), $urandom()};
      send_cmd(cmd);
      if (i < 8) sent.push_back(cmd);   // Ninth lands on a full queue
      check_status("test_cmd_path fill", expect_status(sent.size(), 1, 1'b1), cmd_status);
      check_cmd("test_cmd_path head", sent[0], cmd_data);
    end
    for (int i = 7; i >= 0; i--) begin
      check_cmd("test_cmd_path order", sent.pop_front(), cmd_data);
      pop_cmd();
      check_status("test_cmd_path drain", expect_status(i, 1, 1'b1), cmd_status);
    end
  endtask

  task automatic test_resp_path();
    hci_resp_t sent [$];
    hci_resp_t r;
    logic [31:0] data;
    logic err;
    for (int i = 1; i <= 5; i++) begin
      r = $urandom();
      push_resp(r);
      sent.push_back(r);
      check_status("test_resp_path fill", expect_status(i, 1, 1'b0), resp_status);
    end
    while (sent.size() > 0) begin
      csr_read(`HCI_ADDR_RESPONSE_PORT, data, err);
      check_resp("test_resp_path data", sent.pop_front(), data);
      check_word("test_resp_path rd_err", 32'd0, {31'd0, err});
      check_status("test_resp_path drain", expect_status(sent.size(), 1, 1'b0), resp_status);
    end
    csr_read(`HCI_ADDR_RESPONSE_PORT, data, err);
    check_word("test_resp_path empty data", 32'd0, data);
    check_word("test_resp_path empty rd_err", 32'd0, {31'd0, err});
    check_status("test_resp_path empty", expect_status(0, 1, 1'b0), resp_status);
  endtask

  task automatic test_thresholds();
    logic [31:0] data;
    logic err;
    csr_read(`HCI_ADDR_QUEUE_THLD, data, err);
    check_word("test_thresholds reset value", 32'h0000_0101, data);
    csr_write(`HCI_ADDR_QUEUE_THLD, 32'h0000_0203, err);   // Command 3, response 2
    check_word("test_thresholds wr_err", 32'd0, {31'd0, err});
    csr_read(`HCI_ADDR_QUEUE_THLD, data, err);
    check_word("test_thresholds readback", 32'h0000_0203, data);
    check_status("test_thresholds cmd", expect_status(0, 3, 1'b1), cmd_status);
    check_status("test_thresholds resp", expect_status(0, 2, 1'b0), resp_status);
    for (int k = 1; k <= 7; k++) begin
      send_cmd({$urandom(), $urandom()});
      check_status("test_thresholds cmd", expect_status(k, 3, 1'b1), cmd_status);
    end
    for (int k = 1; k <= 3; k++) begin
      push_resp($urandom());
      check_status("test_thresholds resp", expect_status(k, 2, 1'b0), resp_status);
    end
    // Zero threshold acts as one
    csr_write(`HCI_ADDR_QUEUE_THLD, 32'h0000_0000, err);
    check_status("test_thresholds cmd zero", expect_status(7, 0, 1'b1), cmd_status);
    check_status("test_thresholds resp zero", expect_status(3, 0, 1'b0), resp_status);
    for (int k = 6; k >= 0; k--) begin
      pop_cmd();
      check_status("test_thresholds cmd zero", expect_status(k, 0, 1'b1), cmd_status);
    end
    for (int k = 2; k >= 0; k--) begin
      csr_read(`HCI_ADDR_RESPONSE_PORT, data, err);
      check_status("test_thresholds resp zero", expect_status(k, 0, 1'b0), resp_status);
    end
    csr_write(`HCI_ADDR_QUEUE_THLD, 32'h0000_0101, err);
    csr_read(`HCI_ADDR_QUEUE_THLD, data, err);
    check_word("test_thresholds restore", 32'h0000_0101, data);
  endtask

  task automatic test_soft_reset();
    hci_cmd_t cmd;
    logic [31:0] data;
    logic err;
    for (int k = 0; k < 8; k++) begin
      send_cmd({$urandom(), $urandom()});
      push_resp($urandom());
    end
    check_status("test_soft_reset cmd full", expect_status(8, 1, 1'b1), cmd_status);
    check_status("test_soft_reset resp full", expect_status(8, 1, 1'b0), resp_status);
    csr_write(`HCI_ADDR_COMMAND_PORT, $urandom(), err);   // Half a command pending
    csr_write(`HCI_ADDR_RESET_CTRL, (1 << `HCI_CMD_RST_BIT) | (1 << `HCI_RESP_RST_BIT), err);
    check_word("test_soft_reset wr_err", 32'd0, {31'd0, err});
    @(negedge clk);   // Flush edge
    check_status("test_soft_reset cmd flushed", expect_status(0, 1, 1'b1), cmd_status);
    check_status("test_soft_reset resp flushed", expect_status(0, 1, 1'b0), resp_status);
    csr_read(`HCI_ADDR_RESET_CTRL, data, err);
    check_word("test_soft_reset ctrl cleared", 32'd0, data);
    cmd = {$urandom(), $urandom()};
    send_cmd(cmd);
    check_cmd("test_soft_reset new command", cmd, cmd_data);
    check_status("test_soft_reset one command", expect_status(1, 1, 1'b1), cmd_status);
    pop_cmd();
    check_status("test_soft_reset drained", expect_status(0, 1, 1'b1), cmd_status);
  endtask

  task automatic test_addr_and_errors();
    logic [31:0] data;
    logic err;
    csr_read(`HCI_ADDR_DEVICE_ADDR, data, err);
    check_word("test_addr_and_errors reset value", 32'd0, data);
    dasa_strobe(7'h2a, 1'b1, 1'b0);
    csr_read(`HCI_ADDR_DEVICE_ADDR, data, err);
    check_word("test_addr_and_errors setdasa", 32'h8000_002a, data);
    dasa_strobe(7'h00, 1'b0, 1'b1);
    csr_read(`HCI_ADDR_DEVICE_ADDR, data, err);
    check_word("test_addr_and_errors rstdaa", 32'd0, data);
    dasa_strobe(7'h15, 1'b1, 1'b1);   // Clear wins
    csr_read(`HCI_ADDR_DEVICE_ADDR, data, err);
    check_word("test_addr_and_errors both", 32'd0, data);
    dasa_strobe(7'h33, 1'b1, 1'b0);
    csr_write(`HCI_ADDR_DEVICE_ADDR, 32'hffff_ffff, err);
    check_word("test_addr_and_errors ro wr_err", 32'd1, {31'd0, err});
    csr_read(`HCI_ADDR_DEVICE_ADDR, data, err);
    check_word("test_addr_and_errors unchanged", 32'h8000_0033, data);
    csr_write(`HCI_ADDR_RESPONSE_PORT, 32'h1234_5678, err);
    check_word("test_addr_and_errors resp wr_err", 32'd1, {31'd0, err});
    csr_write(8'h3c, 32'h1234_5678, err);
    check_word("test_addr_and_errors unmapped wr_err", 32'd1, {31'd0, err});
    csr_read(8'h08, data, err);
    check_word("test_addr_and_errors unmapped rd_err", 32'd1, {31'd0, err});
    check_word("test_addr_and_errors unmapped data", 32'd0, data);
  endtask

  initial begin
    void'($urandom(Seed));
    cpu_req = '0;
    cmd_pop = 1'b0;
    resp_push = 1'b0;
    resp_data = '0;
    set_dasa = '0;
    set_dasa_valid = 1'b0;
    rstdaa = 1'b0;
    rst_n = 1'b0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    check_word("reset rsp strobes", 32'd0, {30'd0, cpu_rsp.rd_ack, cpu_rsp.wr_ack});
    check_status("reset cmd queue", expect_status(0, 1, 1'b1), cmd_status);
    check_status("reset resp queue", expect_status(0, 1, 1'b0), resp_status);
    test_cmd_path();
    test_resp_path();
    test_thresholds();
    test_soft_reset();
    test_addr_and_errors();
    $display("test passed");
    $finish;
  end

endmodule

// File: flist.f
+incdir+include
rtl/hci_pkg.sv
rtl/hci_queue.sv
rtl/hci_csr.sv
rtl/hci_top.sv
bench/hci_sva.sv
bench/hci_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the HCI front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -f flist.f --top-module hci_tb \
  -Mdir "$build_dir" -o hci_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$build_dir/hci_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "test passed" "$log_file"; then
  echo "Simulation finished, pass message found"
  exit 0
fi

echo "Pass message not found in $log_file"
exit 1
